// ==== source/lc3b_cache_pkg.sv ====
package lc3b_cache_pkg;

  // address split is tag | index | byte offset
  localparam int offset_bits = 4;
  localparam int index_bits = 3;
  localparam int tag_bits = 9;

  localparam int num_sets = 8;
  localparam int num_ways = 2;

  localparam int line_bits = 128; // sixteen bytes per line

  // one CPU word access, held stable while stb is high
  typedef struct packed {
    logic [15:0] adr;
    logic [15:0] dat;
    logic [1:0]  sel; // bit 1 enables the high byte
    logic        we;
  } cpu_req_t;

  // one line transfer on the memory port
  typedef struct packed {
    logic [15:0]          adr; // always line aligned
    logic [line_bits-1:0] dat;
    logic                 we;
  } mem_req_t;

  // a line seen as words for read select and fill, as bytes for the write merge
  typedef union packed {
    logic [7:0][15:0] words;
    logic [15:0][7:0] bytes;
  } cache_line_u;

  typedef enum logic [2:0] {
    idle      = 3'd0,
    lookup    = 3'd1,
    writeback = 3'd2,
    fill      = 3'd3,
    respond   = 3'd4
  } ctrl_state_e;

endpackage : lc3b_cache_pkg

// ==== source/cache_datapath.sv ====
module cache_datapath (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [15:0]                          adr,
  input  lc3b_cache_pkg::cache_line_u          line_in,
  input  logic                                 array_load,
  input  logic                                 lru_load,
  input  logic                                 mark_dirty,
  output logic                                 hit,
  output logic                                 victim_dirty,
  output logic [lc3b_cache_pkg::tag_bits-1:0]  victim_tag,
  output lc3b_cache_pkg::cache_line_u          line_out
);

  logic [lc3b_cache_pkg::index_bits-1:0] idx;
  logic [lc3b_cache_pkg::tag_bits-1:0]   adr_tag;

  // payload arrays
  logic [lc3b_cache_pkg::tag_bits-1:0] tag_q
      [lc3b_cache_pkg::num_ways][lc3b_cache_pkg::num_sets];
  lc3b_cache_pkg::cache_line_u data_q
      [lc3b_cache_pkg::num_ways][lc3b_cache_pkg::num_sets];

  // control bits, cleared by reset
  logic [lc3b_cache_pkg::num_ways-1:0][lc3b_cache_pkg::num_sets-1:0] valid_q;
  logic [lc3b_cache_pkg::num_ways-1:0][lc3b_cache_pkg::num_sets-1:0] dirty_q;
  logic [lc3b_cache_pkg::num_sets-1:0]                               lru_q; // least recently used way

  logic [lc3b_cache_pkg::num_ways-1:0] hit_way;
  logic                                lru_way;
  logic                                sel_way;

  always_comb begin
    idx = adr[lc3b_cache_pkg::offset_bits +: lc3b_cache_pkg::index_bits];
    adr_tag = adr[lc3b_cache_pkg::offset_bits + lc3b_cache_pkg::index_bits +:
                  lc3b_cache_pkg::tag_bits];
  end

  always_comb begin
    for (int w = 0; w < lc3b_cache_pkg::num_ways; w++) begin
      hit_way[w] = valid_q[w][idx] && (tag_q[w][idx] == adr_tag);
    end
  end

  always_comb begin
    hit = |hit_way;
    lru_way = lru_q[idx];
    sel_way = hit ? hit_way[1] : lru_way; // on a miss the LRU way is replaced
  end

  always_comb begin
    victim_dirty = valid_q[lru_way][idx] && dirty_q[lru_way][idx];
    victim_tag = tag_q[lru_way][idx];
    line_out = data_q[sel_way][idx];
  end

  // line and tag storage
  always_ff @(posedge clk) begin
    if (array_load) begin
      data_q[sel_way][idx] <= line_in;
      tag_q[sel_way][idx] <= adr_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (array_load) begin
      valid_q[sel_way][idx] <= 1'b1;
      dirty_q[sel_way][idx] <= mark_dirty; // a fill comes in clean
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lru_q <= '0;
    end else if (lru_load) begin
      lru_q[idx] <= ~sel_way; // the other way becomes the next victim
    end
  end

endmodule : cache_datapath

// ==== source/cache_control.sv ====
module cache_control (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stb,
  input  logic                        we,
  input  logic                        hit,
  input  logic                        victim_dirty,
  input  logic                        mem_ack,
  output logic                        ack,
  output logic                        mem_cyc,
  output logic                        mem_stb,
  output logic                        mem_we,
  output logic                        array_load,
  output logic                        lru_load,
  output logic                        mark_dirty,
  output logic                        fill_sel,
  output lc3b_cache_pkg::ctrl_state_e state
);

  lc3b_cache_pkg::ctrl_state_e next_state;

  logic mem_gap_q; // one idle bus cycle between write-back and fill
  logic xfer_done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= lc3b_cache_pkg::idle;
      mem_gap_q <= 1'b0;
    end else begin
      state <= next_state;
      mem_gap_q <= xfer_done;
    end
  end

  always_comb begin
    next_state = state;
    ack = 1'b0;
    mem_cyc = 1'b0;
    mem_we = 1'b0;
    array_load = 1'b0;
    lru_load = 1'b0;
    mark_dirty = 1'b0;
    fill_sel = 1'b0;
    xfer_done = 1'b0;

    unique case (state)
      lc3b_cache_pkg::idle: begin
        if (stb) begin
          next_state = lc3b_cache_pkg::lookup;
        end
      end

      lc3b_cache_pkg::lookup: begin
        if (hit) begin
          array_load = we; // write hit merges into the line
          mark_dirty = we;
          lru_load = 1'b1;
          next_state = lc3b_cache_pkg::respond;
        end else if (victim_dirty) begin
          next_state = lc3b_cache_pkg::writeback;
        end else begin
          next_state = lc3b_cache_pkg::fill;
        end
      end

      lc3b_cache_pkg::writeback: begin
        mem_cyc = !mem_gap_q;
        mem_we = 1'b1;
        xfer_done = mem_cyc && mem_ack;
        if (xfer_done) begin
          next_state = lc3b_cache_pkg::fill;
        end
      end

      lc3b_cache_pkg::fill: begin
        mem_cyc = !mem_gap_q; // the gap cycle after a write-back keeps the bus low
        fill_sel = 1'b1;
        xfer_done = mem_cyc && mem_ack;
        if (xfer_done) begin
          array_load = 1'b1;
          next_state = lc3b_cache_pkg::lookup;
        end
      end

      lc3b_cache_pkg::respond: begin
        ack = 1'b1;
        next_state = lc3b_cache_pkg::idle;
      end

      default: begin
        next_state = lc3b_cache_pkg::idle;
      end
    endcase

    mem_stb = mem_cyc; // single transfer per cycle, so the strobe follows cyc
  end

endmodule : cache_control

// ==== source/cache.sv ====
module cache (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stb,
  input  lc3b_cache_pkg::cpu_req_t req,
  output logic                     ack,
  output logic [15:0]              rdata,
  output logic                     mem_cyc,
  output logic                     mem_stb,
  output lc3b_cache_pkg::mem_req_t mem_req,
  input  logic                     mem_ack,
  input  logic [127:0]             mem_rdata
);

  logic                                hit;
  logic                                victim_dirty;
  logic [lc3b_cache_pkg::tag_bits-1:0] victim_tag;
  logic                                array_load;
  logic                                lru_load;
  logic                                mark_dirty;
  logic                                fill_sel;
  logic                                mem_we;
  lc3b_cache_pkg::ctrl_state_e         state;

  lc3b_cache_pkg::cache_line_u line_out;
  lc3b_cache_pkg::cache_line_u merged;
  lc3b_cache_pkg::cache_line_u line_in;

  logic [2:0]                          word_sel;
  logic [lc3b_cache_pkg::tag_bits-1:0] line_tag;

  // word select and byte merge work on the same line from the datapath
  always_comb begin
    word_sel = req.adr[3:1];
    rdata = line_out.words[word_sel];
    merged = line_out;
    if (req.sel[0]) begin
      merged.bytes[{word_sel, 1'b0}] = req.dat[7:0];
    end
    if (req.sel[1]) begin
      merged.bytes[{word_sel, 1'b1}] = req.dat[15:8];
    end
    line_in = fill_sel ? lc3b_cache_pkg::cache_line_u'(mem_rdata) : merged;
  end

  // write-back goes to the victim's address, a fill to the CPU's line
  always_comb begin
    if (state == lc3b_cache_pkg::writeback) begin
      line_tag = victim_tag;
    end else begin
      line_tag = req.adr[15 -: lc3b_cache_pkg::tag_bits];
    end
    mem_req.adr = {line_tag,
                   req.adr[lc3b_cache_pkg::offset_bits +: lc3b_cache_pkg::index_bits],
                   {lc3b_cache_pkg::offset_bits{1'b0}}};
    mem_req.dat = line_out;
    mem_req.we = mem_we;
  end

  cache_datapath u_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .adr          (req.adr),
    .line_in      (line_in),
    .array_load   (array_load),
    .lru_load     (lru_load),
    .mark_dirty   (mark_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .line_out     (line_out)
  );

  cache_control u_control (
    .clk          (clk),
    .rst_n        (rst_n),
    .stb          (stb),
    .we           (req.we),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .mem_ack      (mem_ack),
    .ack          (ack),
    .mem_cyc      (mem_cyc),
    .mem_stb      (mem_stb),
    .mem_we       (mem_we),
    .array_load   (array_load),
    .lru_load     (lru_load),
    .mark_dirty   (mark_dirty),
    .fill_sel     (fill_sel),
    .state        (state)
  );

endmodule : cache

// ==== tests/line_memory_model.sv ====
module line_memory_model (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     mem_cyc,
  input  logic                     mem_stb,
  input  lc3b_cache_pkg::mem_req_t mem_req,
  output logic                     mem_ack,
  output logic [127:0]             mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [127:0] lines [4096];
  logic [31:0]  delay_rng;
  logic [1:0]   wait_cnt;
  logic         busy;

  function automatic logic [31:0] step_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every word carries its own byte address folded into random bits
  initial begin
    logic [31:0] r;
    r = 32'h75f04a4f;
    for (int i = 0; i < 4096; i++) begin
      for (int w = 0; w < 8; w++) begin
        r = step_random(r);
        lines[i][16*w +: 16] = r[31:16] ^ {i[11:0], w[2:0], 1'b0};
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack <= 1'b0;
      mem_rdata <= '0;
      busy <= 1'b0;
      wait_cnt <= 2'd0;
      delay_rng <= 32'h75f04a4f;
    end else begin
      mem_ack <= 1'b0;
      if (mem_cyc && mem_stb && !mem_ack) begin
        if (!busy) begin
          busy <= 1'b1;
          delay_rng <= step_random(delay_rng);
          wait_cnt <= delay_rng[31:30]; // one to four cycles until the ack
        end else if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          busy <= 1'b0;
          mem_ack <= 1'b1;
          if (mem_req.we) begin
            lines[mem_req.adr[15:4]] <= mem_req.dat;
          end else begin
            mem_rdata <= lines[mem_req.adr[15:4]];
          end
        end
      end
    end
  end

endmodule : line_memory_model

// ==== tests/cache_checker.sv ====
module cache_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        stb,
  input logic                        ack,
  input logic                        mem_cyc,
  input logic                        mem_stb,
  input logic                        mem_ack,
  input lc3b_cache_pkg::mem_req_t    mem_req,
  input lc3b_cache_pkg::ctrl_state_e state,
  input logic                        expect_hit,
  input logic                        expect_writeback
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  ack_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else begin
      $error("ack stayed high for more than one cycle");
      fail_count++;
    end

  stb_in_cycle_a: assert property (@(posedge clk) disable iff (!rst_n) mem_stb |-> mem_cyc)
    else begin
      $error("mem_stb high while mem_cyc is low");
      fail_count++;
    end

  // the request may only change once memory has acknowledged it
  mem_req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && !mem_ack |=> $stable(mem_req))
    else begin
      $error("mem_req changed during an open memory transfer");
      fail_count++;
    end

  reset_exit_a: assert property (@(posedge clk) $rose(rst_n) |-> !ack && !mem_cyc && !mem_stb)
    else begin
      $error("ack or memory strobes high right after reset release");
      fail_count++;
    end

  hit_timing_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(stb) && expect_hit |-> !ack && !mem_cyc ##1 !ack && !mem_cyc ##1 ack)
    else begin
      $error("predicted hit was not acknowledged two cycles after the request");
      fail_count++;
    end

  dirty_victim_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(stb) && expect_writeback |->
      ##2 state == lc3b_cache_pkg::writeback && mem_cyc && mem_req.we)
    else begin
      $error("miss on a dirty victim did not start with a memory write");
      fail_count++;
    end

endmodule : cache_checker

// ==== tests/tb_cache.sv ====
module tb_cache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_accesses = 400;
  localparam int timeout_cycles = num_accesses * 50; // worst miss is about 20 cycles

  logic                     clk;
  logic                     rst_n;
  logic                     stb;
  lc3b_cache_pkg::cpu_req_t req;
  logic                     ack;
  logic [15:0]              rdata;
  logic                     mem_cyc;
  logic                     mem_stb;
  lc3b_cache_pkg::mem_req_t mem_req;
  logic                     mem_ack;
  logic [127:0]             mem_rdata;

  logic [15:0]  shadow [256]; // the 32 lines in use, word by word
  logic [8:0]   res_tag [8][2];
  logic         res_valid [8][2];
  logic         res_dirty [8][2];
  logic         res_lru [8];
  logic [15:0]  exp_rdata;
  logic         expect_hit;
  logic         expect_writeback;
  logic [127:0] wb_line;
  int           cycle_count = 0;

  cache u_cache (
    .clk       (clk),
    .rst_n     (rst_n),
    .stb       (stb),
    .req       (req),
    .ack       (ack),
    .rdata     (rdata),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  line_memory_model u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  bind cache cache_checker u_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .stb              (stb),
    .ack              (ack),
    .mem_cyc          (mem_cyc),
    .mem_stb          (mem_stb),
    .mem_ack          (mem_ack),
    .mem_req          (mem_req),
    .state            (state),
    .expect_hit       (tb_cache.expect_hit),
    .expect_writeback (tb_cache.expect_writeback)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    stop_with_failure($sformatf("mismatch at %0d ns: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  function automatic logic predict_hit(input logic [15:0] adr);
    logic [2:0] s;
    logic [8:0] t;
    s = adr[6:4];
    t = adr[15:7];
    return (res_valid[s][0] && res_tag[s][0] == t) || (res_valid[s][1] && res_tag[s][1] == t);
  endfunction

  // a miss evicts the LRU way, which must go back to memory if it was written
  function automatic logic predict_writeback(input logic [15:0] adr);
    logic [2:0] s;
    logic       v;
    s = adr[6:4];
    v = res_lru[s];
    return !predict_hit(adr) && res_valid[s][v] && res_dirty[s][v];
  endfunction

  // two ways per set, the way just used is never the next victim
  task automatic update_residency(input logic [15:0] adr, input logic we);
    logic [2:0] s;
    logic [8:0] t;
    logic       w;
    s = adr[6:4];
    t = adr[15:7];
    if (res_valid[s][1] && res_tag[s][1] == t) begin
      w = 1'b1;
    end else if (res_valid[s][0] && res_tag[s][0] == t) begin
      w = 1'b0;
    end else begin
      w = res_lru[s];
      res_tag[s][w] = t;
      res_valid[s][w] = 1'b1;
      res_dirty[s][w] = 1'b0;
    end
    if (we) begin
      res_dirty[s][w] = 1'b1;
    end
    res_lru[s] = ~w;
  endtask

  task automatic run_access(input logic [15:0] adr, input logic [15:0] dat,
                            input logic [1:0] sel, input logic we);
    exp_rdata = shadow[adr[8:1]];
    expect_hit = predict_hit(adr);
    expect_writeback = predict_writeback(adr);
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    req.we = we;
    stb = 1'b1;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    if (we && sel[0]) begin
      shadow[adr[8:1]][7:0] = dat[7:0];
    end
    if (we && sel[1]) begin
      shadow[adr[8:1]][15:8] = dat[15:8];
    end
    update_residency(adr, we);
    @(posedge clk);
    #1 stb = 1'b0;
    @(posedge clk);
    #1;
  endtask

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      wb_line[16*k +: 16] = shadow[{mem_req.adr[8:4], k[2:0]}];
    end
  end

  read_data_a: assert property (@(posedge clk) disable iff (!rst_n)
      ack && !req.we |-> rdata == exp_rdata)
    else report_mismatch("rdata", {112'd0, $sampled(rdata)}, {112'd0, exp_rdata});

  wb_align_a: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && mem_req.we |-> mem_req.adr[3:0] == 4'd0)
    else stop_with_failure("write-back address is not line aligned");

  wb_data_a: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && mem_req.we |-> mem_req.dat == wb_line)
    else report_mismatch("mem_req.dat", $sampled(mem_req.dat), $sampled(wb_line));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      stop_with_failure($sformatf("timeout after %0d cycles before all accesses finished",
                                  cycle_count));
    end else if (u_cache.u_checker.fail_count != 0) begin
      stop_with_failure("a protocol assertion in the cache checker failed");
    end
  end

  initial begin
    logic [31:0] rng;
    logic [1:0]  sel;
    rng = 32'h75f04a4f;
    rst_n = 1'b0;
    stb = 1'b0;
    req = '0;
    exp_rdata = '0;
    expect_hit = 1'b0;
    expect_writeback = 1'b0;
    for (int s = 0; s < 8; s++) begin
      res_lru[s] = 1'b0;
      res_valid[s][0] = 1'b0;
      res_valid[s][1] = 1'b0;
      res_dirty[s][0] = 1'b0;
      res_dirty[s][1] = 1'b0;
      res_tag[s][0] = '0;
      res_tag[s][1] = '0;
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = u_mem.lines[i[7:3]][16*i[2:0] +: 16];
    end

    // 32 lines over 8 sets gives four tags competing for two ways
    repeat (num_accesses) begin
      rng = lcg_step(rng);
      sel = rng[22:21];
      if (sel == 2'b00) begin
        sel = 2'b11;
      end
      run_access({7'd0, rng[31:24], 1'b0}, rng[15:0], sel, rng[23]);
    end

    repeat (2) @(posedge clk);
    if (u_cache.u_checker.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_failure("the cache checker reported a failed assertion");
    end
  end

endmodule : tb_cache

// ==== lc3b_cache.f ====
source/lc3b_cache_pkg.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache.sv
tests/line_memory_model.sv
tests/cache_checker.sv
tests/tb_cache.sv

// ==== Makefile ====
srcs := $(shell cat lc3b_cache.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cache: lc3b_cache.f $(srcs)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_cache -f lc3b_cache.f -o Vtb_cache

run: obj_dir/Vtb_cache
	-./obj_dir/Vtb_cache +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
